// ==== build.f ====
hdl/ibuf_pkg.sv
hdl/sdp_bank.sv
hdl/fetch_packer.sv
hdl/bank_fifo.sv
hdl/issue_select.sv
hdl/inst_buffer.sv
testbench/inst_buffer_assert.sv
testbench/inst_buffer_tb.sv

// ==== Makefile ====
TOP = inst_buffer_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== testbench/inst_buffer_tb.sv ====
`default_nettype none

module inst_buffer_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BANK = 4;
    localparam int DEPTH = 4;
    localparam int CAP = BANK * DEPTH;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_CYCLES = 3000;
    localparam int PHASE_LEN = 200; // Cycles per drain pattern.

    logic                       clk;
    logic                       rst;
    logic                       fetch_valid;
    logic [BANK-1:0]            fetch_mask;
    ibuf_pkg::inst_t [BANK-1:0] fetch_words;
    logic                       fetch_stall;
    logic                       flush;
    ibuf_pkg::cnt_t             dec_want;
    logic [BANK-1:0]            dec_valid;
    ibuf_pkg::inst_t [BANK-1:0] dec_words;
    logic                       ready;

    ibuf_pkg::inst_t model_q [$]; // Words in taken order.
    logic            model_ready;
    int              sweep_cnt;
    logic [BANK-1:0] exp_valid;
    ibuf_pkg::inst_t exp_words [BANK];
    logic [31:0]     rng;
    logic [15:0]     serial;
    int              full_stalls;
    int              flushes;
    int              issued_words;

    inst_buffer #(
        .BANK(BANK),
        .DEPTH(DEPTH)
    ) uut (
        .clk(clk),
        .rst(rst),
        .fetch_valid(fetch_valid),
        .fetch_mask(fetch_mask),
        .fetch_words(fetch_words),
        .fetch_stall(fetch_stall),
        .flush(flush),
        .dec_want(dec_want),
        .dec_valid(dec_valid),
        .dec_words(dec_words),
        .ready(ready)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped after a failed check");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_mask(input string name, input logic [BANK-1:0] got,
                              input logic [BANK-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input ibuf_pkg::inst_t got,
                              input ibuf_pkg::inst_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic drive_inputs(input int cyc);
        ibuf_pkg::inst_t [BANK-1:0] words;
        logic [31:0]                r;
        logic [31:0]                w;
        int                         phase;
        for (int i = 0; i < BANK; i++) begin
            w = next_rand();
            words[i] = {w[31:16], serial}; // Serial keeps every word distinct.
            serial = serial + 16'd1;
        end
        r = next_rand();
        phase = (cyc / PHASE_LEN) % 3;
        rst <= cyc < RESET_CYCLES - 1;
        fetch_valid <= r[1:0] != 2'b00;
        fetch_mask <= r[27:24];
        fetch_words <= words;
        flush <= (r[7:2] == 6'd0) && (cyc >= RESET_CYCLES);
        if (phase == 0) begin
            dec_want <= ibuf_pkg::cnt_t'(r[15:8] % (BANK + 1));
        end else if (phase == 1) begin
            // Slow decode so the buffer fills up.
            dec_want <= (r[18:16] == 3'd0) ? ibuf_pkg::cnt_t'(r[15:8] % (BANK + 1)) : '0;
        end else begin
            dec_want <= ibuf_pkg::cnt_t'(BANK - int'(r[8]));
        end
    endtask

    // Checks this cycle's outputs, then advances the model over the coming edge.
    task automatic check_and_step();
        ibuf_pkg::inst_t packed_w [$];
        int              pnum;
        int              occ;
        int              avail;
        int              tnum;
        logic            take;
        if (rst) begin
            check_bit("ready", ready, 1'b0);
            check_bit("fetch_stall", fetch_stall, fetch_valid);
            check_mask("dec_valid", dec_valid, '0);
            model_q.delete();
            model_ready = 1'b0;
            sweep_cnt = 0;
            exp_valid = '0;
        end else begin
            for (int i = 0; i < BANK; i++) begin
                if (fetch_mask[i]) begin
                    packed_w.push_back(fetch_words[i]);
                end
            end
            pnum = packed_w.size();
            occ = model_q.size();
            take = fetch_valid && model_ready && !flush && (CAP - occ >= pnum);
            avail = (!model_ready || flush) ? 0 : ((occ < BANK) ? occ : BANK);
            tnum = (int'(dec_want) < avail) ? int'(dec_want) : avail;

            check_bit("ready", ready, model_ready);
            check_bit("fetch_stall", fetch_stall, fetch_valid && !take);
            check_mask("dec_valid", dec_valid, exp_valid);
            for (int i = 0; i < BANK; i++) begin
                if (exp_valid[i]) begin
                    check_word($sformatf("dec_words[%0d]", i), dec_words[i], exp_words[i]);
                end
            end

            exp_valid = '0;
            for (int i = 0; i < tnum; i++) begin
                exp_valid[i] = 1'b1;
                exp_words[i] = model_q.pop_front();
            end
            issued_words += tnum;
            if (flush) begin
                model_q.delete();
                flushes++;
            end else if (take) begin
                foreach (packed_w[i]) begin
                    model_q.push_back(packed_w[i]);
                end
            end else if (fetch_valid && model_ready) begin
                full_stalls++; // No room for this packet.
            end
            if (!model_ready) begin
                sweep_cnt++;
                if (sweep_cnt == DEPTH) begin
                    model_ready = 1'b1;
                end
            end
        end
    endtask

    initial begin
        rng = 32'd51;
        serial = '0;
        full_stalls = 0;
        flushes = 0;
        issued_words = 0;
        model_ready = 1'b0;
        sweep_cnt = 0;
        exp_valid = '0;
        rst = 1'b1;
        fetch_valid = 1'b0;
        fetch_mask = '0;
        fetch_words = '0;
        flush = 1'b0;
        dec_want = '0;
        for (int cyc = 0; cyc < RESET_CYCLES + NUM_CYCLES; cyc++) begin
            @(posedge clk);
            drive_inputs(cyc);
            @(negedge clk);
            check_and_step();
        end
        if (full_stalls > 0 && flushes > 0 && issued_words > 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            fail_run("The stimulus never reached a full buffer, a flush or a decode take");
        end
    end

    initial begin
        #((RESET_CYCLES + NUM_CYCLES + 50) * 20);
        fail_run("Timeout: the test did not finish in the expected time");
    end

endmodule

`default_nettype wire

// ==== testbench/inst_buffer_assert.sv ====
`default_nettype none

module inst_buffer_assert #(
    parameter int BANK = 4
) (
    input logic                  clk,
    input logic                  rst,
    input logic                  ready,
    input logic [BANK-1:0]       dec_valid,
    input ibuf_pkg::bank_state_e state
);
    timeunit 1ns;
    timeprecision 1ps;

    a_low_contig: assert property (@(posedge clk) disable iff (rst)
        (dec_valid & (dec_valid + BANK'(1))) == '0)
        else $error("dec_valid is not a low-contiguous mask");

    a_quiet_in_sweep: assert property (@(posedge clk) disable iff (rst)
        !ready |-> dec_valid == '0)
        else $error("dec_valid is set while ready is low");

    a_no_second_sweep: assert property (@(posedge clk) disable iff (rst)
        state == ibuf_pkg::BUF_RUN |=> state == ibuf_pkg::BUF_RUN)
        else $error("bank state went back to the clearing sweep without a reset");

endmodule

bind inst_buffer inst_buffer_assert #(.BANK(BANK)) u_assert (
    .clk(clk),
    .rst(rst),
    .ready(ready),
    .dec_valid(dec_valid),
    .state(u_fifo.state)
);

`default_nettype wire

// ==== hdl/inst_buffer.sv ====
`default_nettype none

module inst_buffer #(
    parameter int BANK = 4,
    parameter int DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        fetch_valid,
    input  logic [BANK-1:0]             fetch_mask,
    input  ibuf_pkg::inst_t [BANK-1:0]  fetch_words,
    output logic                        fetch_stall,
    input  logic                        flush,
    input  ibuf_pkg::cnt_t              dec_want,
    output logic [BANK-1:0]             dec_valid,
    output ibuf_pkg::inst_t [BANK-1:0]  dec_words,
    output logic                        ready
);

    ibuf_pkg::cnt_t             pack_num;
    ibuf_pkg::inst_t [BANK-1:0] pack_words;
    ibuf_pkg::cnt_t             avail;
    ibuf_pkg::inst_t [BANK-1:0] head_words;
    ibuf_pkg::cnt_t             take_num;

    if (BANK > ibuf_pkg::MAX_BANK) begin : g_bank_check
        $error("inst_buffer: BANK is larger than MAX_BANK");
    end

    fetch_packer #(
        .BANK(BANK)
    ) u_packer (
        .fetch_mask(fetch_mask),
        .fetch_words(fetch_words),
        .pack_num(pack_num),
        .pack_words(pack_words)
    );

    bank_fifo #(
        .BANK(BANK),
        .DEPTH(DEPTH)
    ) u_fifo (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .fetch_valid(fetch_valid),
        .pack_num(pack_num),
        .pack_words(pack_words),
        .take_num(take_num),
        .fetch_stall(fetch_stall),
        .avail(avail),
        .head_words(head_words),
        .ready(ready)
    );

    issue_select #(
        .BANK(BANK)
    ) u_issue (
        .clk(clk),
        .rst(rst),
        .dec_want(dec_want),
        .avail(avail),
        .head_words(head_words),
        .take_num(take_num),
        .dec_valid(dec_valid),
        .dec_words(dec_words)
    );

endmodule

`default_nettype wire

// ==== hdl/issue_select.sv ====
`default_nettype none

module issue_select #(
    parameter int BANK = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  ibuf_pkg::cnt_t              dec_want,
    input  ibuf_pkg::cnt_t              avail,
    input  ibuf_pkg::inst_t [BANK-1:0]  head_words,
    output ibuf_pkg::cnt_t              take_num,
    output logic [BANK-1:0]             dec_valid,
    output ibuf_pkg::inst_t [BANK-1:0]  dec_words
);

    logic [ibuf_pkg::MAX_BANK-1:0] take_mask;

    assign take_num = ibuf_pkg::min_cnt(dec_want, avail);
    assign take_mask = ibuf_pkg::low_mask(take_num);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_valid <= '0;
        end else begin
            dec_valid <= take_mask[BANK-1:0];
        end
    end

    // Words beyond the take count are carried but never marked valid.
    always_ff @(posedge clk) begin
        dec_words <= head_words;
    end

endmodule

`default_nettype wire

// ==== hdl/bank_fifo.sv ====
`default_nettype none

module bank_fifo #(
    parameter int BANK = 4,
    parameter int DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  logic                        fetch_valid,
    input  ibuf_pkg::cnt_t              pack_num,
    input  ibuf_pkg::inst_t [BANK-1:0]  pack_words,
    input  ibuf_pkg::cnt_t              take_num,
    output logic                        fetch_stall,
    output ibuf_pkg::cnt_t              avail,
    output ibuf_pkg::inst_t [BANK-1:0]  head_words,
    output logic                        ready
);

    localparam int BW = $clog2(BANK);
    localparam int AW = $clog2(DEPTH);
    localparam int CAP = BANK * DEPTH;
    localparam int OW = $clog2(CAP + 1);

    ibuf_pkg::bank_state_e state;
    logic [AW-1:0]   sweep_row;
    logic [BW-1:0]   head;
    logic [BW-1:0]   tail;
    logic [OW-1:0]   occ;
    logic [OW-1:0]   free_cnt;
    logic            take;
    logic [AW-1:0]   waddr_q [BANK];
    logic [AW-1:0]   raddr_q [BANK];
    logic [BANK-1:0] we;
    logic [BANK-1:0] ren;
    ibuf_pkg::inst_t rdata [BANK];

    assign ready = state == ibuf_pkg::BUF_RUN;
    assign free_cnt = OW'(CAP) - occ;
    assign take = fetch_valid & ready & ~flush & (free_cnt >= OW'(pack_num));
    assign fetch_stall = fetch_valid & ~take;

    always_comb begin
        if (!ready || flush) begin
            avail = '0;
        end else if (occ >= OW'(BANK)) begin
            avail = ibuf_pkg::cnt_t'(BANK);
        end else begin
            avail = ibuf_pkg::cnt_t'(occ);
        end
    end

    for (genvar b = 0; b < BANK; b++) begin : g_bank
        logic [BW-1:0]   wofs;
        logic [BW-1:0]   rofs;
        logic [AW-1:0]   waddr;
        ibuf_pkg::inst_t wdata;

        assign wofs = BW'(b) - tail; // Slot of the packet this bank takes.
        assign rofs = BW'(b) - head;
        assign we[b] = ~ready | (take & (ibuf_pkg::cnt_t'(wofs) < pack_num));
        assign ren[b] = ibuf_pkg::cnt_t'(rofs) < take_num;
        assign waddr = ready ? waddr_q[b] : sweep_row;
        assign wdata = ready ? pack_words[wofs] : '0;

        sdp_bank #(
            .DEPTH(DEPTH),
            .READ_LATENCY(0)
        ) u_bank (
            .clk(clk),
            .waddr(waddr),
            .we(we[b]),
            .wdata(wdata),
            .en(ren[b]),
            .raddr(raddr_q[b]),
            .rdata(rdata[b])
        );

        assign head_words[b] = rdata[head + BW'(b)]; // Oldest word first.
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ibuf_pkg::BUF_CLEAR;
            sweep_row <= '0;
        end else if (state == ibuf_pkg::BUF_CLEAR) begin
            sweep_row <= sweep_row + 1'b1;
            if (sweep_row == AW'(DEPTH - 1)) begin
                state <= ibuf_pkg::BUF_RUN;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            occ <= '0;
            for (int b = 0; b < BANK; b++) begin
                waddr_q[b] <= '0;
                raddr_q[b] <= '0;
            end
        end else if (flush) begin
            head <= '0; // Contents are dropped, rows stay as they are.
            tail <= '0;
            occ <= '0;
            for (int b = 0; b < BANK; b++) begin
                waddr_q[b] <= '0;
                raddr_q[b] <= '0;
            end
        end else begin
            if (take) begin
                tail <= tail + BW'(pack_num); // Wraps over the banks.
            end
            head <= head + BW'(take_num);
            occ <= occ + (take ? OW'(pack_num) : '0) - OW'(take_num);
            for (int b = 0; b < BANK; b++) begin
                if (we[b] && ready) begin
                    waddr_q[b] <= waddr_q[b] + 1'b1;
                end
                if (ren[b]) begin
                    raddr_q[b] <= raddr_q[b] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_packer.sv ====
`default_nettype none

module fetch_packer #(
    parameter int BANK = 4
) (
    input  logic [BANK-1:0]             fetch_mask,
    input  ibuf_pkg::inst_t [BANK-1:0]  fetch_words,
    output ibuf_pkg::cnt_t              pack_num,
    output ibuf_pkg::inst_t [BANK-1:0]  pack_words
);

    ibuf_pkg::cnt_t pos [BANK+1]; // Valid words below each slot.

    always_comb begin
        pos[0] = '0;
        for (int i = 0; i < BANK; i++) begin
            pos[i+1] = pos[i] + ibuf_pkg::cnt_t'(fetch_mask[i]);
        end
    end

    assign pack_num = pos[BANK];

    // A word at slot i can only move down, so slot j looks at i >= j.
    always_comb begin
        pack_words = '0;
        for (int j = 0; j < BANK; j++) begin
            for (int i = j; i < BANK; i++) begin
                if (fetch_mask[i] && pos[i] == ibuf_pkg::cnt_t'(j)) begin
                    pack_words[j] = fetch_words[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sdp_bank.sv ====
`default_nettype none

module sdp_bank #(
    parameter int DEPTH = 4,
    parameter int READ_LATENCY = 0
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic                     we,
    input  ibuf_pkg::inst_t          wdata,
    input  logic                     en,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output ibuf_pkg::inst_t          rdata
);

    ibuf_pkg::inst_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    if (READ_LATENCY == 0) begin : g_comb_read
        assign rdata = mem[raddr]; // Read during write sees the old row.
    end else begin : g_reg_read
        always_ff @(posedge clk) begin
            if (en) begin
                rdata <= mem[raddr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ibuf_pkg.sv ====
`default_nettype none

package ibuf_pkg;

    localparam int INST_W = 32;
    localparam int MAX_BANK = 8;
    localparam int CNT_W = $clog2(MAX_BANK) + 1; // Holds 0 to MAX_BANK.

    typedef logic [INST_W-1:0] inst_t;
    typedef logic [CNT_W-1:0] cnt_t;

    typedef enum logic {
        BUF_CLEAR,
        BUF_RUN
    } bank_state_e;

    function automatic cnt_t min_cnt(input cnt_t a, input cnt_t b);
        return (a < b) ? a : b;
    endfunction

    // Low-contiguous mask with n bits set.
    function automatic logic [MAX_BANK-1:0] low_mask(input cnt_t n);
        logic [MAX_BANK-1:0] m;
        for (int i = 0; i < MAX_BANK; i++) begin
            m[i] = cnt_t'(i) < n;
        end
        return m;
    endfunction

endpackage

`default_nettype wire
